//--- Bender.yml
package:
  name: aes_accel

sources:
  - include_dirs:
      - source
    files:
      - source/aes_pkg.sv
      - source/aes_if.sv
      - source/aes_cipher_core.sv
      - source/aes_slot.sv
      - source/aes_slot_arbiter.sv
      - source/aes_regfile.sv
      - source/aes_accel.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/aes_accel_tb.sv

//--- dv/aes_accel_tb.sv
`default_nettype none

`include "aes_config.svh"

module aes_accel_tb;

    // 20 runs of at most 50 cycles plus about 110 bus cycles each, with margin
    localparam int TIMEOUT_CYCLES = 5000;

    localparam logic [0:255][7:0] SBOX = {
        128'h637c777bf26b6fc53001672bfed7ab76, 128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115, 128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84, 128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8, 128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973, 128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479, 128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a, 128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df, 128'h8ca1890dbfe6426841992d0fb054bb16
    };
    localparam logic [0:9][7:0] RCON = {
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10, 8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    localparam aes_pkg::block_t KAT_KEY = 128'h000102030405060708090a0b0c0d0e0f;
    localparam aes_pkg::block_t KAT_PT  = 128'h00112233445566778899aabbccddeeff;
    localparam aes_pkg::block_t KAT_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    logic            clk_i;
    logic            rst_ni;
    logic            cs_i;
    logic            we_i;
    aes_pkg::word_t  addr_i;
    aes_pkg::word_t  wdata_i;
    aes_pkg::word_t  rdata_o;
    logic            irq_o;

    logic [31:0]     lcg_state;
    int              cycle_count = 0;
    int              irq_count = 0;
    int              irq_cycle = 0;
    int              start_cycle;
    int              irq_base;
    aes_pkg::block_t key_m    [4];
    aes_pkg::block_t block_m  [4];
    aes_pkg::block_t result_m [4];

    aes_accel dut0 (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .cs_i    (cs_i),
        .we_i    (we_i),
        .addr_i  (addr_i),
        .wdata_i (wdata_i),
        .rdata_o (rdata_o),
        .irq_o   (irq_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (rst_ni && irq_o) begin
            irq_count <= irq_count + 1;
            irq_cycle <= cycle_count + 1; // edge at which the pulse was seen
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        abort_run($sformatf("timeout: the tests did not end within %0d cycles", TIMEOUT_CYCLES));
    end

    task automatic check_block(input string name, input aes_pkg::block_t expected,
                               input aes_pkg::block_t actual);
        if (actual !== expected)
            abort_run($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic check_word(input string name, input aes_pkg::word_t expected,
                              input aes_pkg::word_t actual);
        if (actual !== expected)
            abort_run($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            abort_run($sformatf("FAIL %s expected %b actual %b", name, expected, actual));
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic aes_pkg::block_t random_block();
        return {next_random(), next_random(), next_random(), next_random()};
    endfunction

    function automatic logic [7:0] mul2(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // byte i of the state is row i%4 of column i/4, as in FIPS-197
    function automatic aes_pkg::block_t ref_encrypt(input aes_pkg::block_t key,
                                                    input aes_pkg::block_t pt);
        logic [31:0]     w [44];
        logic [31:0]     t;
        logic [7:0]      s [16];
        logic [7:0]      u [16];
        aes_pkg::block_t ct;
        for (int i = 0; i < 4; i++) w[i] = key[127 - 32 * i -: 32];
        for (int i = 4; i < 44; i++) begin
            t = w[i - 1];
            if (i % 4 == 0)
                t = {SBOX[t[23:16]], SBOX[t[15:8]], SBOX[t[7:0]], SBOX[t[31:24]]}
                    ^ {RCON[i / 4 - 1], 24'h0};
            w[i] = w[i - 4] ^ t;
        end
        for (int i = 0; i < 16; i++) s[i] = pt[127 - 8 * i -: 8] ^ w[i / 4][31 - 8 * (i % 4) -: 8];
        for (int rnd = 1; rnd <= 10; rnd++) begin
            for (int c = 0; c < 4; c++)
                for (int row = 0; row < 4; row++)
                    u[4 * c + row] = SBOX[s[4 * ((c + row) % 4) + row]];
            for (int c = 0; c < 4; c++)
                for (int row = 0; row < 4; row++)
                    if (rnd == 10) s[4 * c + row] = u[4 * c + row];
                    else s[4 * c + row] = mul2(u[4 * c + row]) ^ mul2(u[4 * c + (row + 1) % 4])
                        ^ u[4 * c + (row + 1) % 4] ^ u[4 * c + (row + 2) % 4]
                        ^ u[4 * c + (row + 3) % 4];
            for (int i = 0; i < 16; i++) s[i] ^= w[4 * rnd + i / 4][31 - 8 * (i % 4) -: 8];
        end
        for (int i = 0; i < 16; i++) ct[127 - 8 * i -: 8] = s[i];
        return ct;
    endfunction

    // every bus task starts and ends one time unit after a rising edge
    task automatic bus_write(input aes_pkg::word_t addr, input aes_pkg::word_t data);
        cs_i    = 1'b1;
        we_i    = 1'b1;
        addr_i  = addr;
        wdata_i = data;
        @(posedge clk_i);
        #1;
        cs_i = 1'b0;
        we_i = 1'b0;
    endtask

    task automatic bus_read(input aes_pkg::word_t addr, output aes_pkg::word_t data);
        cs_i   = 1'b1;
        we_i   = 1'b0;
        addr_i = addr;
        @(negedge clk_i);
        data = rdata_o;
        @(posedge clk_i);
        #1;
        cs_i = 1'b0;
    endtask

    task automatic load_slot(input int slot, input aes_pkg::block_t key,
                             input aes_pkg::block_t blk);
        for (int w = 0; w < 4; w++) begin
            bus_write(`AES_ADDR_KEY_BASE + 16 * slot + 4 * w, key[127 - 32 * w -: 32]);
            bus_write(`AES_ADDR_BLOCK_BASE + 16 * slot + 4 * w, blk[127 - 32 * w -: 32]);
        end
        key_m[slot]   = key;
        block_m[slot] = blk;
    endtask

    task automatic read_result(input int slot, output aes_pkg::block_t res);
        aes_pkg::word_t data;
        for (int w = 0; w < 4; w++) begin
            bus_read(`AES_ADDR_RESULT_BASE + 16 * slot + 4 * w, data);
            res[127 - 32 * w -: 32] = data;
        end
    endtask

    task automatic check_results(input string name);
        aes_pkg::block_t res;
        for (int s = 0; s < 4; s++) begin
            read_result(s, res);
            check_block($sformatf("%s slot %0d result", name, s), result_m[s], res);
        end
    endtask

    task automatic start_run(input string name, input logic [3:0] mask);
        aes_pkg::word_t st;
        aes_pkg::word_t ctrl;
        bus_write(`AES_ADDR_CTRL, 32'(mask));
        bus_read(`AES_ADDR_CTRL, ctrl);
        check_word({name, " enable mask readback"}, 32'(mask), ctrl);
        irq_base = irq_count;
        bus_write(`AES_ADDR_START, 32'h1);
        start_cycle = cycle_count;
        bus_read(`AES_ADDR_STATUS, st);
        check_word({name, " status while busy"}, 32'h0, st); // ready 0 and done 0
    endtask

    task automatic finish_run(input string name, input logic [3:0] mask);
        aes_pkg::word_t st;
        do begin
            bus_read(`AES_ADDR_STATUS, st);
        end while (!(st[`AES_STATUS_DONE_BIT] && st[`AES_STATUS_READY_BIT]));
        check_word({name, " irq count"}, 32'(irq_base + 1), 32'(irq_count));
        // clear cycle, then a grant cycle and 11 core cycles per enabled slot
        check_word({name, " run length"}, 32'(2 + 12 * $countones(mask)),
                   32'(irq_cycle - start_cycle));
        for (int s = 0; s < 4; s++)
            if (mask[s]) result_m[s] = ref_encrypt(key_m[s], block_m[s]);
        check_results(name);
    endtask

    initial begin
        aes_pkg::word_t  st;
        aes_pkg::word_t  exp_status;
        aes_pkg::block_t res;
        logic [31:0]     rnd;
        logic [3:0]      mask;

        rst_ni    = 1'b0;
        cs_i      = 1'b0;
        we_i      = 1'b0;
        addr_i    = '0;
        wdata_i   = '0;
        lcg_state = 32'd42716;
        for (int s = 0; s < 4; s++) begin
            key_m[s]    = '0;
            block_m[s]  = '0;
            result_m[s] = '0;
        end
        repeat (8) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        exp_status = '0;
        exp_status[`AES_STATUS_READY_BIT] = 1'b1;
        exp_status[`AES_STATUS_DONE_BIT]  = 1'b1;
        bus_read(`AES_ADDR_STATUS, st);
        check_word("reset status", exp_status, st);
        check_results("reset");
        check_bit("reset irq level", 1'b0, irq_o);
        check_word("reset irq count", 32'h0, 32'(irq_count));

        check_block("kat model", KAT_CT, ref_encrypt(KAT_KEY, KAT_PT));
        load_slot(0, KAT_KEY, KAT_PT);
        start_run("kat", 4'b0001);
        finish_run("kat", 4'b0001);
        read_result(0, res);
        check_block("kat result", KAT_CT, res);

        for (int i = 0; i < 16; i++) begin
            for (int s = 0; s < 4; s++) load_slot(s, random_block(), random_block());
            rnd  = next_random();
            mask = rnd[27:24];
            if (mask == 4'b0000) mask = 4'b0001;
            start_run($sformatf("random run %0d", i), mask);
            finish_run($sformatf("random run %0d", i), mask);
        end

        // a second start during the run is dropped by the regfile
        start_run("overlap", 4'b1010);
        bus_write(`AES_ADDR_START, 32'h1);
        bus_read(`AES_ADDR_STATUS, st);
        check_word("overlap status after second start", 32'h0, st);
        finish_run("overlap", 4'b1010);
        repeat (30) @(posedge clk_i);
        #1;
        check_word("overlap irq count after idle", 32'(irq_base + 1), 32'(irq_count));

        load_slot(0, random_block(), random_block());
        load_slot(1, random_block(), random_block());
        start_run("side writes", 4'b0011);
        load_slot(2, random_block(), random_block()); // slots 2 and 3 sit out this run
        load_slot(3, random_block(), random_block());
        finish_run("side writes", 4'b0011);
        start_run("deferred slots", 4'b1100);
        finish_run("deferred slots", 4'b1100);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/aes_accel.sv
`default_nettype none

`include "aes_config.svh"

module aes_accel (
    input  wire logic            clk_i,
    input  wire logic            rst_ni,
    input  wire logic            cs_i,
    input  wire logic            we_i,
    input  wire aes_pkg::word_t  addr_i,
    input  wire aes_pkg::word_t  wdata_i,
    output aes_pkg::word_t       rdata_o,
    output logic                 irq_o
);

    aes_slot_bus_if slot_bus [`AES_NUM_SLOTS] ();
    aes_core_if     core_bus ();

    logic                      reg_start;  // accepted start write
    logic                      run_start;  // clear pulse to the slots
    logic [`AES_NUM_SLOTS-1:0] enable;
    logic                      busy;
    logic                      run_done;
    logic [`AES_NUM_SLOTS-1:0] result_we;
    aes_pkg::block_t           result;
    aes_pkg::block_t           slot_key   [`AES_NUM_SLOTS];
    aes_pkg::block_t           slot_block [`AES_NUM_SLOTS];

    aes_regfile regfile0 (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .cs_i        (cs_i),
        .we_i        (we_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .rdata_o     (rdata_o),
        .irq_o       (irq_o),
        .slot_bus    (slot_bus),
        .run_start_o (reg_start),
        .enable_o    (enable),
        .busy_i      (busy),
        .run_done_i  (run_done)
    );

    for (genvar g = 0; g < `AES_NUM_SLOTS; g++) begin : g_slot
        aes_slot slot0 (
            .clk_i       (clk_i),
            .rst_ni      (rst_ni),
            .bus         (slot_bus[g]),
            .run_start_i (run_start),
            .result_we_i (result_we[g]),
            .result_i    (result),
            .key_o       (slot_key[g]),
            .block_o     (slot_block[g])
        );
    end

    aes_slot_arbiter arbiter0 (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .start_i     (reg_start),
        .enable_i    (enable),
        .busy_o      (busy),
        .run_done_o  (run_done),
        .run_start_o (run_start),
        .result_we_o (result_we),
        .result_o    (result),
        .key_i       (slot_key),
        .block_i     (slot_block),
        .core        (core_bus)
    );

    aes_cipher_core core0 (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .core   (core_bus)
    );

endmodule

`default_nettype wire

//--- source/aes_cipher_core.sv
`default_nettype none

`include "aes_config.svh"

module aes_cipher_core (
    input  wire logic clk_i,
    input  wire logic rst_ni,
    aes_core_if.core  core
);

    aes_pkg::block_t state_q;
    aes_pkg::block_t key_q;
    aes_pkg::block_t key_next;
    aes_pkg::block_t sr_state;
    aes_pkg::block_t mc_state;
    logic [3:0]      round_q;
    logic            busy_q;
    logic            done_q;
    logic            last_round;

    assign last_round = (round_q == 4'(`AES_ROUNDS));

    // next round key from the current one
    always_comb begin
        logic [31:0] temp;
        temp = {aes_pkg::sbox(key_q[23:16]), aes_pkg::sbox(key_q[15:8]),
                aes_pkg::sbox(key_q[7:0]), aes_pkg::sbox(key_q[31:24])};
        temp ^= {aes_pkg::rcon(round_q), 24'h0};
        key_next[127:96] = key_q[127:96] ^ temp;
        key_next[95:64]  = key_q[95:64] ^ key_next[127:96];
        key_next[63:32]  = key_q[63:32] ^ key_next[95:64];
        key_next[31:0]   = key_q[31:0] ^ key_next[63:32];
    end

    // SubBytes and ShiftRows, byte i is row i%4 of column i/4
    always_comb begin
        int src;
        for (int i = 0; i < 16; i++) begin
            src = 4 * (((i / 4) + (i % 4)) % 4) + (i % 4);
            sr_state[127 - 8 * i -: 8] = aes_pkg::sbox(state_q[127 - 8 * src -: 8]);
        end
    end

    always_comb begin
        logic [31:0] col;
        logic [7:0]  a0;
        logic [7:0]  a1;
        logic [7:0]  a2;
        logic [7:0]  a3;
        for (int c = 0; c < 4; c++) begin
            col = sr_state[127 - 32 * c -: 32];
            a0  = col[31:24];
            a1  = col[23:16];
            a2  = col[15:8];
            a3  = col[7:0];
            mc_state[127 - 32 * c -: 32] = {
                aes_pkg::xtime(a0) ^ aes_pkg::xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ aes_pkg::xtime(a1) ^ aes_pkg::xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ aes_pkg::xtime(a2) ^ aes_pkg::xtime(a3) ^ a3,
                aes_pkg::xtime(a0) ^ a0 ^ a1 ^ a2 ^ aes_pkg::xtime(a3)
            };
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            round_q <= '0;
        end else begin
            done_q <= 1'b0;
            if (core.start) begin
                busy_q  <= 1'b1;
                round_q <= 4'd1;
            end else if (busy_q) begin
                round_q <= round_q + 4'd1;
                if (last_round) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (core.start) begin
            state_q <= core.block ^ core.key; // initial AddRoundKey
            key_q   <= core.key;
        end else if (busy_q) begin
            state_q <= (last_round ? sr_state : mc_state) ^ key_next;
            key_q   <= key_next;
        end
    end

    assign core.busy   = busy_q;
    assign core.done   = done_q;
    assign core.result = state_q;

endmodule

`default_nettype wire

//--- source/aes_config.svh
`ifndef AES_CONFIG_SVH
`define AES_CONFIG_SVH

`define AES_NUM_SLOTS 4

// register map, byte addresses
`define AES_ADDR_CTRL        32'h0000_0000
`define AES_ADDR_START       32'h0000_0004
`define AES_ADDR_STATUS      32'h0000_0008
`define AES_ADDR_BLOCK_BASE  32'h0000_0010
`define AES_ADDR_KEY_BASE    32'h0000_0050
`define AES_ADDR_RESULT_BASE 32'h0000_0090

`define AES_STATUS_READY_BIT 0
`define AES_STATUS_DONE_BIT  1

`define AES_ROUNDS 10

`endif

//--- source/aes_if.sv
`default_nettype none

// register side of one job slot
interface aes_slot_bus_if;
    logic                   we;
    aes_pkg::slot_field_e   field;
    aes_pkg::word_idx_t     word;
    aes_pkg::word_t         wdata;
    aes_pkg::word_t         rdata; // addressed result word, combinational

    modport regs (
        output we, field, word, wdata,
        input  rdata
    );

    modport slot (
        input  we, field, word, wdata,
        output rdata
    );
endinterface

// arbiter to cipher core
interface aes_core_if;
    logic            start;
    aes_pkg::block_t key;
    aes_pkg::block_t block;
    logic            busy;
    logic            done;
    aes_pkg::block_t result; // valid while done is high

    modport arb (
        output start, key, block,
        input  busy, done, result
    );

    modport core (
        input  start, key, block,
        output busy, done, result
    );
endinterface

`default_nettype wire

//--- source/aes_pkg.sv
`default_nettype none

package aes_pkg;

    typedef logic [127:0] block_t; // word 0 sits in bits 127:96
    typedef logic [31:0]  word_t;
    typedef logic [1:0]   slot_idx_t;
    typedef logic [1:0]   word_idx_t;

    typedef enum logic [1:0] {
        FIELD_BLOCK,
        FIELD_KEY,
        FIELD_RESULT
    } slot_field_e;

    function automatic logic [7:0] xtime(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] t;
        p = '0;
        t = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) p ^= t;
            t = xtime(t);
        end
        return p;
    endfunction

    // multiplicative inverse as x^254, then the affine map
    function automatic logic [7:0] sbox(input logic [7:0] x);
        logic [7:0] sq;
        logic [7:0] inv;
        sq  = x;
        inv = 8'h01;
        for (int i = 1; i < 8; i++) begin
            sq  = gf_mul(sq, sq);
            inv = gf_mul(inv, sq);
        end
        return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
            ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    endfunction

    function automatic logic [7:0] rcon(input logic [3:0] round);
        case (round)
            4'd1:    return 8'h01;
            4'd2:    return 8'h02;
            4'd3:    return 8'h04;
            4'd4:    return 8'h08;
            4'd5:    return 8'h10;
            4'd6:    return 8'h20;
            4'd7:    return 8'h40;
            4'd8:    return 8'h80;
            4'd9:    return 8'h1b;
            4'd10:   return 8'h36;
            default: return 8'h00;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- source/aes_regfile.sv
`default_nettype none

`include "aes_config.svh"

module aes_regfile (
    input  wire logic                      clk_i,
    input  wire logic                      rst_ni,
    input  wire logic                      cs_i,
    input  wire logic                      we_i,
    input  wire aes_pkg::word_t            addr_i,
    input  wire aes_pkg::word_t            wdata_i,
    output aes_pkg::word_t                 rdata_o,
    output logic                           irq_o,
    aes_slot_bus_if.regs                   slot_bus [`AES_NUM_SLOTS],
    output logic                           run_start_o,
    output logic [`AES_NUM_SLOTS-1:0]      enable_o,
    input  wire logic                      busy_i,
    input  wire logic                      run_done_i
);

    logic [`AES_NUM_SLOTS-1:0] enable_q;
    logic                      done_q;
    logic                      in_slot;
    aes_pkg::slot_field_e      field;
    aes_pkg::word_t            offset;
    aes_pkg::slot_idx_t        slot_idx;
    aes_pkg::word_idx_t        word_idx;
    aes_pkg::word_t            status;
    aes_pkg::word_t            slot_rdata [`AES_NUM_SLOTS];

    always_comb begin
        in_slot = 1'b1;
        field   = aes_pkg::FIELD_BLOCK;
        offset  = addr_i - `AES_ADDR_BLOCK_BASE;
        if (addr_i >= `AES_ADDR_BLOCK_BASE && addr_i < `AES_ADDR_KEY_BASE) begin
            field = aes_pkg::FIELD_BLOCK;
        end else if (addr_i >= `AES_ADDR_KEY_BASE && addr_i < `AES_ADDR_RESULT_BASE) begin
            field  = aes_pkg::FIELD_KEY;
            offset = addr_i - `AES_ADDR_KEY_BASE;
        end else if (addr_i >= `AES_ADDR_RESULT_BASE
                     && addr_i < `AES_ADDR_RESULT_BASE + 16 * `AES_NUM_SLOTS) begin
            field  = aes_pkg::FIELD_RESULT;
            offset = addr_i - `AES_ADDR_RESULT_BASE;
        end else begin
            in_slot = 1'b0;
        end
    end

    assign slot_idx = offset[5:4];
    assign word_idx = offset[3:2];

    for (genvar g = 0; g < `AES_NUM_SLOTS; g++) begin : g_slot_bus
        assign slot_bus[g].we    = cs_i && we_i && in_slot && (slot_idx == g)
                                   && (field != aes_pkg::FIELD_RESULT);
        assign slot_bus[g].field = field;
        assign slot_bus[g].word  = word_idx;
        assign slot_bus[g].wdata = wdata_i;
        assign slot_rdata[g]     = slot_bus[g].rdata;
    end

    // a start during a run is dropped here
    assign run_start_o = cs_i && we_i && (addr_i == `AES_ADDR_START) && wdata_i[0] && !busy_i;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            enable_q <= '0;
            done_q   <= 1'b1; // empty mask counts as complete
        end else begin
            if (cs_i && we_i && addr_i == `AES_ADDR_CTRL) enable_q <= wdata_i[`AES_NUM_SLOTS-1:0];
            if (run_start_o) done_q <= 1'b0;
            else if (run_done_i) done_q <= 1'b1;
        end
    end

    always_comb begin
        status = '0;
        status[`AES_STATUS_READY_BIT] = !busy_i;
        status[`AES_STATUS_DONE_BIT]  = done_q;
    end

    always_comb begin
        rdata_o = '0;
        if (cs_i && !we_i) begin
            if (addr_i == `AES_ADDR_CTRL) rdata_o[`AES_NUM_SLOTS-1:0] = enable_q;
            else if (addr_i == `AES_ADDR_STATUS) rdata_o = status;
            else if (in_slot && field == aes_pkg::FIELD_RESULT) rdata_o = slot_rdata[slot_idx];
        end
    end

    assign enable_o = enable_q;
    assign irq_o    = run_done_i;

endmodule

`default_nettype wire

//--- source/aes_slot.sv
`default_nettype none

module aes_slot (
    input  wire logic             clk_i,
    input  wire logic             rst_ni,
    aes_slot_bus_if.slot          bus,
    input  wire logic             run_start_i,
    input  wire logic             result_we_i,
    input  wire aes_pkg::block_t  result_i,
    output aes_pkg::block_t       key_o,
    output aes_pkg::block_t       block_o
);

    aes_pkg::word_t  key_q   [4];
    aes_pkg::word_t  block_q [4];
    aes_pkg::block_t result_q;
    logic            valid_q;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            for (int i = 0; i < 4; i++) begin
                key_q[i]   <= '0;
                block_q[i] <= '0;
            end
            result_q <= '0;
            valid_q  <= 1'b0;
        end else begin
            if (bus.we) begin
                case (bus.field)
                    aes_pkg::FIELD_BLOCK: block_q[bus.word] <= bus.wdata;
                    aes_pkg::FIELD_KEY:   key_q[bus.word]   <= bus.wdata;
                    default: ;            // results are read only
                endcase
            end
            if (run_start_i) begin
                valid_q <= 1'b0;
            end else if (result_we_i && !valid_q) begin
                // one result per run
                result_q <= result_i;
                valid_q  <= 1'b1;
            end
        end
    end

    assign key_o     = {key_q[0], key_q[1], key_q[2], key_q[3]};
    assign block_o   = {block_q[0], block_q[1], block_q[2], block_q[3]};
    assign bus.rdata = result_q[127 - 32 * bus.word -: 32];

endmodule

`default_nettype wire

//--- source/aes_slot_arbiter.sv
`default_nettype none

`include "aes_config.svh"

module aes_slot_arbiter (
    input  wire logic                       clk_i,
    input  wire logic                       rst_ni,
    input  wire logic                       start_i,
    input  wire logic [`AES_NUM_SLOTS-1:0]  enable_i,
    output logic                            busy_o,
    output logic                            run_done_o,
    output logic                            run_start_o,
    output logic [`AES_NUM_SLOTS-1:0]       result_we_o,
    output aes_pkg::block_t                 result_o,
    input  wire aes_pkg::block_t            key_i   [`AES_NUM_SLOTS],
    input  wire aes_pkg::block_t            block_i [`AES_NUM_SLOTS],
    aes_core_if.arb                         core
);

    typedef enum logic [1:0] {S_IDLE, S_CLEAR, S_GRANT, S_WAIT} state_e;

    state_e              state_q;
    aes_pkg::slot_idx_t  idx_q;
    aes_pkg::slot_idx_t  next_idx;
    logic                next_found;
    logic                run_done_q;

    // lowest enabled slot above the current one, or from 0 in the clear cycle
    always_comb begin
        next_found = 1'b0;
        next_idx   = '0;
        for (int i = `AES_NUM_SLOTS - 1; i >= 0; i--) begin
            if (enable_i[i] && (state_q == S_CLEAR || i > int'(idx_q))) begin
                next_found = 1'b1;
                next_idx   = aes_pkg::slot_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q    <= S_IDLE;
            idx_q      <= '0;
            run_done_q <= 1'b0;
        end else begin
            run_done_q <= 1'b0;
            case (state_q)
                S_IDLE: if (start_i) state_q <= S_CLEAR;
                S_GRANT: state_q <= S_WAIT;
                S_CLEAR, S_WAIT: begin
                    if (state_q == S_CLEAR || core.done) begin
                        if (next_found) begin
                            state_q <= S_GRANT;
                            idx_q   <= next_idx;
                        end else begin
                            state_q    <= S_IDLE;
                            run_done_q <= 1'b1;
                        end
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    assign busy_o      = (state_q != S_IDLE) || run_done_q;
    assign run_done_o  = run_done_q;
    assign run_start_o = (state_q == S_CLEAR); // slots drop their valid flags

    assign core.start = (state_q == S_GRANT);
    assign core.key   = key_i[idx_q];
    assign core.block = block_i[idx_q];

    always_comb begin
        result_we_o = '0;
        if (state_q == S_WAIT && core.done) result_we_o[idx_q] = 1'b1;
    end

    assign result_o = core.result;

endmodule

`default_nettype wire

//--- src.f
+incdir+source
source/aes_pkg.sv
source/aes_if.sv
source/aes_cipher_core.sv
source/aes_slot.sv
source/aes_slot_arbiter.sv
source/aes_regfile.sv
source/aes_accel.sv
dv/aes_accel_tb.sv
